//--- include/axi_sram_consts.svh
// Widths and depth are fixed here; index width must equal log2 of the depth
`ifndef AXI_SRAM_CONSTS_SVH
`define AXI_SRAM_CONSTS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define AXI_SRAM_ADDR_W 32
`define AXI_SRAM_DATA_W 64
`define AXI_SRAM_STRB_W (`AXI_SRAM_DATA_W / 8)
`define AXI_SRAM_ID_W 4

// ----------------------------------------
// Memory geometry
// ----------------------------------------
`define AXI_SRAM_DEPTH 256
`define AXI_SRAM_IDX_W 8

// ----------------------------------------
// Response codes
// ----------------------------------------
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

//--- source/axi_pkg.sv
// AXI4 channel payloads only; lock, cache and prot are carried but never interpreted
`include "axi_sram_consts.svh"

package axi_pkg;

  // Write address channel
  typedef struct packed {
    logic [`AXI_SRAM_ID_W-1:0]   id;
    logic [`AXI_SRAM_ADDR_W-1:0] addr;
    logic [7:0]                  len;
    logic [2:0]                  size;
    logic [1:0]                  burst;
    logic                        lock;
    logic [3:0]                  cache;
    logic [2:0]                  prot;
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_SRAM_DATA_W-1:0] data;
    logic [`AXI_SRAM_STRB_W-1:0] strb;
    logic                        last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_SRAM_ID_W-1:0] id;
    logic [1:0]                resp;
  } axi_b_t;

  // Read address channel with the AW layout
  typedef struct packed {
    logic [`AXI_SRAM_ID_W-1:0]   id;
    logic [`AXI_SRAM_ADDR_W-1:0] addr;
    logic [7:0]                  len;
    logic [2:0]                  size;
    logic [1:0]                  burst;
    logic                        lock;
    logic [3:0]                  cache;
    logic [2:0]                  prot;
  } axi_ar_t;

  typedef struct packed {
    logic [`AXI_SRAM_ID_W-1:0]   id;
    logic [`AXI_SRAM_DATA_W-1:0] data;
    logic [1:0]                  resp;
    logic                        last;
  } axi_r_t;

endpackage

//--- source/sram_pkg.sv
// Word-indexed SRAM ports; the index already excludes the byte offset bits
`include "axi_sram_consts.svh"

package sram_pkg;

  // Byte-strobed write port
  typedef struct packed {
    logic                        en;
    logic [`AXI_SRAM_IDX_W-1:0]  idx;
    logic [`AXI_SRAM_DATA_W-1:0] data;
    logic [`AXI_SRAM_STRB_W-1:0] strb;
  } sram_wr_t;

  // Read port with data one cycle later
  typedef struct packed {
    logic                       en;
    logic [`AXI_SRAM_IDX_W-1:0] idx;
  } sram_rd_t;

endpackage

//--- source/axi_sram_wr_ctrl.sv
// Single-beat writes only; nonzero len or out-of-range address gives SLVERR without a write
`timescale 1ns/1ps
`include "axi_sram_consts.svh"

module axi_sram_wr_ctrl (
  input  logic                i_aclk,
  input  logic                i_arst_n,
  input  axi_pkg::axi_aw_t    i_aw,
  input  logic                i_awvalid,
  output logic                o_awready,
  input  axi_pkg::axi_w_t     i_w,
  input  logic                i_wvalid,
  output logic                o_wready,
  output axi_pkg::axi_b_t     o_b,
  output logic                o_bvalid,
  input  logic                i_bready,
  output sram_pkg::sram_wr_t  o_sram_wr
);

  localparam int IDX_LSB = $clog2(`AXI_SRAM_STRB_W);
  localparam int IDX_MSB = IDX_LSB + `AXI_SRAM_IDX_W - 1;

  typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_RESP} state_t;

  state_t                     state_q;
  state_t                     state_d;
  logic                       awready_q;
  logic                       wready_q;
  logic                       bvalid_q;
  logic [`AXI_SRAM_ID_W-1:0]  id_q;
  logic [`AXI_SRAM_IDX_W-1:0] idx_q;
  logic                       good_q;
  logic                       aw_fire;
  logic                       w_fire;
  logic                       b_fire;

  assign aw_fire = i_awvalid & awready_q;
  assign w_fire  = i_wvalid & wready_q;
  assign b_fire  = bvalid_q & i_bready;

  // ----------------------------------------
  // State machine
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (aw_fire) state_d = ST_DATA;
      ST_DATA: if (w_fire) state_d = ST_RESP;
      ST_RESP: if (b_fire) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  // Handshake flags follow the next state, so all are low during reset
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= ST_IDLE;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      awready_q <= (state_d == ST_IDLE);
      wready_q  <= (state_d == ST_DATA);
      bvalid_q  <= (state_d == ST_RESP);
    end
  end

  // Request capture and error decision
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      id_q   <= i_aw.id;
      idx_q  <= i_aw.addr[IDX_MSB:IDX_LSB];
      good_q <= (i_aw.addr[`AXI_SRAM_ADDR_W-1:IDX_MSB+1] == '0) && (i_aw.len == 8'd0);
    end
  end

  // Write goes straight to the array on the W beat
  always_comb begin
    o_sram_wr.en   = w_fire & good_q;
    o_sram_wr.idx  = idx_q;
    o_sram_wr.data = i_w.data;
    o_sram_wr.strb = i_w.strb;
  end

  always_comb begin
    o_b.id   = id_q;
    o_b.resp = good_q ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
  end

  assign o_awready = awready_q;
  assign o_wready  = wready_q;
  assign o_bvalid  = bvalid_q;

endmodule

//--- source/axi_sram_rd_ctrl.sv
// Single-beat reads only; errored reads return SLVERR with zero data and rlast set
`timescale 1ns/1ps
`include "axi_sram_consts.svh"

module axi_sram_rd_ctrl (
  input  logic                         i_aclk,
  input  logic                         i_arst_n,
  input  axi_pkg::axi_ar_t             i_ar,
  input  logic                         i_arvalid,
  output logic                         o_arready,
  output axi_pkg::axi_r_t              o_r,
  output logic                         o_rvalid,
  input  logic                         i_rready,
  output sram_pkg::sram_rd_t           o_sram_rd,
  input  logic [`AXI_SRAM_DATA_W-1:0]  i_sram_rdata
);

  localparam int IDX_LSB = $clog2(`AXI_SRAM_STRB_W);
  localparam int IDX_MSB = IDX_LSB + `AXI_SRAM_IDX_W - 1;

  typedef enum logic {ST_IDLE, ST_WAIT} state_t;

  state_t                    state_q;
  state_t                    state_d;
  logic                      arready_q;
  logic                      rvalid_q;
  logic [`AXI_SRAM_ID_W-1:0] id_q;
  logic                      good_q;
  logic                      ar_fire;
  logic                      r_fire;

  assign ar_fire = i_arvalid & arready_q;
  assign r_fire  = rvalid_q & i_rready;

  // ----------------------------------------
  // State machine
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (ar_fire) state_d = ST_WAIT;
      ST_WAIT: if (r_fire) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= ST_IDLE;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      arready_q <= (state_d == ST_IDLE);
      rvalid_q  <= (state_d == ST_WAIT);
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q   <= i_ar.id;
      good_q <= (i_ar.addr[`AXI_SRAM_ADDR_W-1:IDX_MSB+1] == '0) && (i_ar.len == 8'd0);
    end
  end

  // Array read issued on the AR beat with the word ready one cycle later
  always_comb begin
    o_sram_rd.en  = ar_fire;
    o_sram_rd.idx = i_ar.addr[IDX_MSB:IDX_LSB];
  end

  always_comb begin
    o_r.id   = id_q;
    o_r.data = good_q ? i_sram_rdata : '0;
    o_r.resp = good_q ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
    o_r.last = 1'b1;
  end

  assign o_arready = arready_q;
  assign o_rvalid  = rvalid_q;

endmodule

//--- source/sram_array.sv
// Contents undefined until written; a read colliding with a write returns the old word
`timescale 1ns/1ps
`include "axi_sram_consts.svh"

module sram_array (
  input  logic                         i_aclk,
  input  sram_pkg::sram_wr_t           i_wr,
  input  sram_pkg::sram_rd_t           i_rd,
  output logic [`AXI_SRAM_DATA_W-1:0]  o_rdata
);

  logic [`AXI_SRAM_DATA_W-1:0] mem [`AXI_SRAM_DEPTH];
  logic [`AXI_SRAM_DATA_W-1:0] rdata_q;

  // ----------------------------------------
  // Byte-strobed write port
  // ----------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_wr.en) begin
      for (int b = 0; b < `AXI_SRAM_STRB_W; b++) begin
        if (i_wr.strb[b]) begin
          mem[i_wr.idx][b*8 +: 8] <= i_wr.data[b*8 +: 8];
        end
      end
    end
  end

  // Output register holds its value between reads
  always_ff @(posedge i_aclk) begin
    if (i_rd.en) begin
      rdata_q <= mem[i_rd.idx];
    end
  end

  assign o_rdata = rdata_q;

endmodule

//--- source/axi_sram_top.sv
// AXI4 slave SRAM; read and write channels run independently with no ordering between them
`timescale 1ns/1ps

module axi_sram_top (
  input  logic              i_aclk,
  input  logic              i_arst_n,
  input  axi_pkg::axi_aw_t  i_aw,
  input  logic              i_awvalid,
  output logic              o_awready,
  input  axi_pkg::axi_w_t   i_w,
  input  logic              i_wvalid,
  output logic              o_wready,
  output axi_pkg::axi_b_t   o_b,
  output logic              o_bvalid,
  input  logic              i_bready,
  input  axi_pkg::axi_ar_t  i_ar,
  input  logic              i_arvalid,
  output logic              o_arready,
  output axi_pkg::axi_r_t   o_r,
  output logic              o_rvalid,
  input  logic              i_rready
);

  sram_pkg::sram_wr_t          sram_wr;
  sram_pkg::sram_rd_t          sram_rd;
  logic [$bits(o_r.data)-1:0]  sram_rdata;

  axi_sram_wr_ctrl u_wr_ctrl (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_aw      (i_aw),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_w       (i_w),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_b       (o_b),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_sram_wr (sram_wr)
  );

  axi_sram_rd_ctrl u_rd_ctrl (
    .i_aclk       (i_aclk),
    .i_arst_n     (i_arst_n),
    .i_ar         (i_ar),
    .i_arvalid    (i_arvalid),
    .o_arready    (o_arready),
    .o_r          (o_r),
    .o_rvalid     (o_rvalid),
    .i_rready     (i_rready),
    .o_sram_rd    (sram_rd),
    .i_sram_rdata (sram_rdata)
  );

  sram_array u_array (
    .i_aclk  (i_aclk),
    .i_wr    (sram_wr),
    .i_rd    (sram_rd),
    .o_rdata (sram_rdata)
  );

endmodule

//--- testbench/tb_axi_sram_top.sv
// Needs simulator timing support; reads only target words already written, since the SRAM has no reset
`timescale 1ns/1ps
`include "axi_sram_consts.svh"

module tb_axi_sram_top;

  localparam int TIMEOUT = 50;
  localparam int IDX_LSB = 3;
  localparam int IDX_MSB = 10;
  localparam logic [1:0] OK = `AXI_RESP_OKAY;
  localparam logic [1:0] ERR = `AXI_RESP_SLVERR;

  typedef struct packed {
    logic [8*10-1:0]             name;
    logic                        is_read;
    logic [`AXI_SRAM_ID_W-1:0]   id;
    logic [`AXI_SRAM_ADDR_W-1:0] addr;
    logic [7:0]                  len;
    logic [`AXI_SRAM_DATA_W-1:0] data;
    logic [`AXI_SRAM_STRB_W-1:0] strb;
    logic [3:0]                  delay;
    logic [1:0]                  resp;
  } entry_t;

  // Name, read, id, addr, len, data, strb, ready delay, expected response
  localparam int NUM_ENTRIES = 13;
  localparam entry_t STIM [NUM_ENTRIES] = '{
    '{"wr_full_a ", 1'b0, 4'd1, 32'h00000000, 8'd0, 64'h0123456789abcdef, 8'hff, 4'd0, OK},
    '{"rd_full_a ", 1'b1, 4'd2, 32'h00000000, 8'd0, 64'h0, 8'h00, 4'd1, OK},
    '{"wr_full_b ", 1'b0, 4'd3, 32'h00000010, 8'd0, 64'h1122334455667788, 8'hff, 4'd2, OK},
    '{"wr_part_lo", 1'b0, 4'd4, 32'h00000010, 8'd0, 64'haaaabbbbccccdddd, 8'h0f, 4'd0, OK},
    '{"wr_part_hi", 1'b0, 4'd5, 32'h00000010, 8'd0, 64'hfedcba9876543210, 8'ha0, 4'd1, OK},
    '{"rd_part   ", 1'b1, 4'd6, 32'h00000010, 8'd0, 64'h0, 8'h00, 4'd3, OK},
    '{"wr_len_err", 1'b0, 4'd7, 32'h00000010, 8'd1, 64'hdeadbeefdeadbeef, 8'hff, 4'd0, ERR},
    // Aliases onto word 2 if the range check were missing
    '{"wr_oor_err", 1'b0, 4'd8, 32'h00000810, 8'd0, 64'hcafef00dcafef00d, 8'hff, 4'd2, ERR},
    '{"rd_keep   ", 1'b1, 4'd9, 32'h00000010, 8'd0, 64'h0, 8'h00, 4'd0, OK},
    '{"rd_oor_err", 1'b1, 4'd10, 32'h10000000, 8'd0, 64'h0, 8'h00, 4'd2, ERR},
    '{"rd_len_err", 1'b1, 4'd11, 32'h00000000, 8'd3, 64'h0, 8'h00, 4'd0, ERR},
    '{"wr_top    ", 1'b0, 4'd12, 32'h000007f8, 8'd0, 64'h5a5a5a5a3c3c3c3c, 8'hff, 4'd0, OK},
    '{"rd_top    ", 1'b1, 4'd13, 32'h000007f8, 8'd0, 64'h0, 8'h00, 4'd4, OK}
  };

  logic             i_aclk;
  logic             i_arst_n;
  axi_pkg::axi_aw_t i_aw;
  logic             i_awvalid;
  logic             o_awready;
  axi_pkg::axi_w_t  i_w;
  logic             i_wvalid;
  logic             o_wready;
  axi_pkg::axi_b_t  o_b;
  logic             o_bvalid;
  logic             i_bready;
  axi_pkg::axi_ar_t i_ar;
  logic             i_arvalid;
  logic             o_arready;
  axi_pkg::axi_r_t  o_r;
  logic             o_rvalid;
  logic             i_rready;
  logic [`AXI_SRAM_DATA_W-1:0] shadow [`AXI_SRAM_DEPTH];
  integer           seed;

  // Bit order used by wait_for
  wire [4:0] handshakes = {o_rvalid, o_bvalid, o_arready, o_wready, o_awready};

  axi_sram_top UUT (.*);

  initial begin
    i_aclk = 1'b0;
    forever #2 i_aclk = ~i_aclk;
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic wait_for(input int sel, input string what);
    int cnt;
    cnt = 0;
    while (!handshakes[sel]) begin
      @(negedge i_aclk);
      cnt++;
      if (cnt > TIMEOUT) begin
        fail_now($sformatf("Timeout after %0d cycles waiting for %s", TIMEOUT, what));
      end
    end
  endtask

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < `AXI_SRAM_STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic check_b(input logic [8*10-1:0] name, input axi_pkg::axi_b_t exp,
                         input axi_pkg::axi_b_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected B %h, actual B %h", name, exp, act);
      fail_now("Wrong write response");
    end
  endtask

  task automatic check_r(input logic [8*10-1:0] name, input axi_pkg::axi_r_t exp,
                         input axi_pkg::axi_r_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected R %h, actual R %h", name, exp, act);
      fail_now("Wrong read beat");
    end
  endtask

  // ----------------------------------------
  // Transactions
  // ----------------------------------------
  task automatic run_write(input entry_t e);
    axi_pkg::axi_b_t exp_b;
    logic [`AXI_SRAM_IDX_W-1:0] idx;
    idx = e.addr[IDX_MSB:IDX_LSB];
    exp_b.id = e.id;
    exp_b.resp = e.resp;
    i_aw = '0;
    i_aw.id = e.id;
    i_aw.addr = e.addr;
    i_aw.len = e.len;
    i_aw.size = 3'd3;
    i_aw.burst = 2'b01;
    i_awvalid = 1'b1;
    wait_for(0, "awready");
    @(negedge i_aclk);
    i_awvalid = 1'b0;
    i_w.data = e.data;
    i_w.strb = e.strb;
    i_w.last = 1'b1;
    i_wvalid = 1'b1;
    wait_for(1, "wready");
    @(negedge i_aclk);
    i_wvalid = 1'b0;
    if (e.resp == OK) shadow[idx] = merge_bytes(shadow[idx], e.data, e.strb);
    wait_for(3, "bvalid");
    repeat (e.delay) begin
      check_b(e.name, exp_b, o_b);
      @(negedge i_aclk);
      if (!o_bvalid) fail_now("bvalid dropped while bready was low");
    end
    check_b(e.name, exp_b, o_b);
    i_bready = 1'b1;
    @(negedge i_aclk);
    i_bready = 1'b0;
    if (o_bvalid) fail_now("bvalid still high after the B transfer");
  endtask

  task automatic run_read(input entry_t e);
    axi_pkg::axi_r_t exp_r;
    logic [`AXI_SRAM_IDX_W-1:0] idx;
    idx = e.addr[IDX_MSB:IDX_LSB];
    exp_r.id = e.id;
    exp_r.data = (e.resp == OK) ? shadow[idx] : '0;
    exp_r.resp = e.resp;
    exp_r.last = 1'b1;
    i_ar = '0;
    i_ar.id = e.id;
    i_ar.addr = e.addr;
    i_ar.len = e.len;
    i_ar.size = 3'd3;
    i_ar.burst = 2'b01;
    i_arvalid = 1'b1;
    wait_for(2, "arready");
    @(negedge i_aclk);
    i_arvalid = 1'b0;
    wait_for(4, "rvalid");
    repeat (e.delay) begin
      check_r(e.name, exp_r, o_r);
      @(negedge i_aclk);
      if (!o_rvalid) fail_now("rvalid dropped while rready was low");
    end
    check_r(e.name, exp_r, o_r);
    i_rready = 1'b1;
    @(negedge i_aclk);
    i_rready = 1'b0;
    if (o_rvalid) fail_now("rvalid still high after the R transfer");
  endtask

  // Fill words 0 to 63, then mix random writes and reads over them
  task automatic run_random(input int n_ops);
    entry_t e;
    logic [31:0] r;
    e = '0;
    e.resp = OK;
    for (int i = 0; i < 64; i++) begin
      e.name = "rnd_fill  ";
      e.id = i[3:0];
      e.addr = {23'd0, i[5:0], 3'b000};
      e.data = {$random(seed), $random(seed)};
      e.strb = 8'hff;
      run_write(e);
    end
    for (int i = 0; i < n_ops; i++) begin
      r = $random(seed);
      e.is_read = r[16];
      e.name = r[16] ? "rnd_read  " : "rnd_write ";
      e.id = r[23:20];
      e.addr = {23'd0, r[5:0], 3'b000};
      e.strb = r[15:8];
      e.delay = {1'b0, r[19:17]};
      e.data = {$random(seed), $random(seed)};
      if (e.is_read) run_read(e);
      else run_write(e);
    end
  endtask

  initial begin
    seed = 32'h96ce_67fe;
    i_arst_n = 1'b0;
    i_aw = '0;
    i_awvalid = 1'b0;
    i_w = '0;
    i_wvalid = 1'b0;
    i_bready = 1'b0;
    i_ar = '0;
    i_arvalid = 1'b0;
    i_rready = 1'b0;
    repeat (10) begin
      @(negedge i_aclk);
      if (o_bvalid || o_rvalid) fail_now("bvalid or rvalid high during reset");
      if (o_awready || o_wready || o_arready) fail_now("A ready signal is high during reset");
    end
    i_arst_n = 1'b1;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (STIM[i].is_read) run_read(STIM[i]);
      else run_write(STIM[i]);
    end
    run_random(200);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- files.f
+incdir+include
source/axi_pkg.sv
source/sram_pkg.sv
source/axi_sram_wr_ctrl.sv
source/axi_sram_rd_ctrl.sv
source/sram_array.sv
source/axi_sram_top.sv
testbench/tb_axi_sram_top.sv

//--- Makefile
TOP := tb_axi_sram_top
BUILD := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir $(BUILD) -o V$(TOP)

run: compile
	./$(BUILD)/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log
